//--- hw/soc_pkg.sv
`default_nettype none

package soc_pkg;

    // Bus data and address width
    localparam int XLEN = 32;

    // One mask bit per byte lane
    localparam int MASK_W = XLEN / 8;

    // Address bits that pick a window
    localparam int WIN_MSB = 31;
    localparam int WIN_LSB = 28;

    localparam int WIN_W = WIN_MSB - WIN_LSB + 1;

    // Window codes
    // instruction memory at 0x1000_0000, reset PC of the core
    localparam logic [WIN_W-1:0] IMEM_WIN = 4'h1;
    // data memory at 0x2000_0000
    localparam logic [WIN_W-1:0] DMEM_WIN = 4'h2;
    // PIM register window at 0x4000_0000
    localparam logic [WIN_W-1:0] PIM_WIN = 4'h4;

    // Default depth of each memory in words
    localparam int MEM_WORDS_DEF = 4096;

    // Read data source for the cycle after a read strobe
    typedef enum logic [1:0] {
        WIN_NONE,
        WIN_DMEM,
        WIN_PIM
    } win_e;

endpackage

`default_nettype wire

//--- hw/mem_bus_if.sv
`timescale 1ns/1ps
`default_nettype none

interface mem_bus_if;

    logic [soc_pkg::XLEN-1:0]   addr;
    logic [soc_pkg::XLEN-1:0]   wr_data;
    logic [soc_pkg::XLEN-1:0]   rd_data;
    logic [soc_pkg::MASK_W-1:0] size;
    logic                       read;
    logic                       write;

    // Command side
    modport master (
        output addr,
        output wr_data,
        output size,
        output read,
        output write,
        input  rd_data
    );

    // Memory or register side
    modport slave (
        input  addr,
        input  wr_data,
        input  size,
        input  read,
        input  write,
        output rd_data
    );

endinterface

`default_nettype wire

//--- hw/bus_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module bus_arbiter (
    // Host loader port
    input  logic                       host_req_i,
    input  logic [soc_pkg::XLEN-1:0]   host_addr_i,
    input  logic [soc_pkg::XLEN-1:0]   host_wr_data_i,
    input  logic [soc_pkg::MASK_W-1:0] host_size_i,
    input  logic                       host_read_i,
    input  logic                       host_write_i,
    output logic                       host_gnt_o,

    // Core data port
    input  logic                       core_req_i,
    input  logic [soc_pkg::XLEN-1:0]   core_addr_i,
    input  logic [soc_pkg::XLEN-1:0]   core_wr_data_i,
    input  logic [soc_pkg::MASK_W-1:0] core_size_i,
    input  logic                       core_read_i,
    input  logic                       core_write_i,
    output logic                       core_gnt_o,

    mem_bus_if.master                  bus_o
);

    // Host always wins, core waits with req held
    assign host_gnt_o = host_req_i;
    assign core_gnt_o = core_req_i & ~host_req_i;

    always_comb begin
        if (host_req_i) begin
            bus_o.addr    = host_addr_i;
            bus_o.wr_data = host_wr_data_i;
            bus_o.size    = host_size_i;
            bus_o.read    = host_read_i;
            bus_o.write   = host_write_i;
        end else if (core_req_i) begin
            bus_o.addr    = core_addr_i;
            bus_o.wr_data = core_wr_data_i;
            bus_o.size    = core_size_i;
            bus_o.read    = core_read_i;
            bus_o.write   = core_write_i;
        end else begin
            // Idle bus
            bus_o.addr    = '0;
            bus_o.wr_data = '0;
            bus_o.size    = '0;
            bus_o.read    = 1'b0;
            bus_o.write   = 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- hw/bus_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module bus_decoder (
    input  logic                     clk_i,
    input  logic                     rv_rst_ni,

    // From the arbiter
    mem_bus_if.slave                 bus_i,

    // To the memories
    mem_bus_if.master                dmem_o,
    mem_bus_if.master                imem_o,

    // PIM register window
    input  logic [soc_pkg::XLEN-1:0] pim_rd_i,
    output logic [soc_pkg::XLEN-1:0] pim_addr_o,
    output logic [soc_pkg::XLEN-1:0] pim_wr_o
);

    logic [soc_pkg::WIN_W-1:0] win;
    logic                      hit_imem;
    logic                      hit_dmem;
    logic                      hit_pim;
    soc_pkg::win_e             rd_sel_q;
    logic [soc_pkg::XLEN-1:0]  pim_addr_q;
    logic [soc_pkg::XLEN-1:0]  pim_wr_q;

    assign win      = bus_i.addr[soc_pkg::WIN_MSB:soc_pkg::WIN_LSB];
    assign hit_imem = (win == soc_pkg::IMEM_WIN);
    assign hit_dmem = (win == soc_pkg::DMEM_WIN);
    assign hit_pim  = (win == soc_pkg::PIM_WIN);

    // Data memory sees reads and writes of its own window only
    assign dmem_o.addr    = bus_i.addr;
    assign dmem_o.wr_data = bus_i.wr_data;
    assign dmem_o.size    = bus_i.size;
    assign dmem_o.read    = bus_i.read & hit_dmem;
    assign dmem_o.write   = bus_i.write & hit_dmem;

    // Instruction memory is write only from the bus
    assign imem_o.addr    = bus_i.addr;
    assign imem_o.wr_data = bus_i.wr_data;
    assign imem_o.size    = bus_i.size;
    assign imem_o.read    = 1'b0;
    assign imem_o.write   = bus_i.write & hit_imem;

    // Source of read data for the next cycle
    always_ff @(posedge clk_i or negedge rv_rst_ni) begin
        if (!rv_rst_ni) begin
            rd_sel_q <= soc_pkg::WIN_NONE;
        end else if (bus_i.read) begin
            if (hit_dmem) begin
                rd_sel_q <= soc_pkg::WIN_DMEM;
            end else if (hit_pim) begin
                rd_sel_q <= soc_pkg::WIN_PIM;
            end else begin
                rd_sel_q <= soc_pkg::WIN_NONE;
            end
        end else begin
            rd_sel_q <= soc_pkg::WIN_NONE;
        end
    end

    // Unmapped and imem reads return zero
    always_comb begin
        case (rd_sel_q)
            soc_pkg::WIN_DMEM: bus_i.rd_data = dmem_o.rd_data;
            soc_pkg::WIN_PIM:  bus_i.rd_data = pim_rd_i;
            default:           bus_i.rd_data = '0;
        endcase
    end

    // PIM address and data hold until the next PIM write
    always_ff @(posedge clk_i or negedge rv_rst_ni) begin
        if (!rv_rst_ni) begin
            pim_addr_q <= '0;
            pim_wr_q   <= '0;
        end else if (bus_i.write && hit_pim) begin
            pim_addr_q <= bus_i.addr;
            pim_wr_q   <= bus_i.wr_data;
        end
    end

    assign pim_addr_o = pim_addr_q;
    assign pim_wr_o   = pim_wr_q;

endmodule

`default_nettype wire

//--- hw/imem_banked.sv
`timescale 1ns/1ps
`default_nettype none

module imem_banked #(
    parameter int MEM_WORDS = 4096
) (
    input  logic                     clk_i,

    // Write port from the system bus
    mem_bus_if.slave                 bus_i,

    // Fetch port
    input  logic [soc_pkg::XLEN-1:0] fetch_addr_i,
    output logic [soc_pkg::XLEN-1:0] fetch_rd_data_o
);

    localparam int IDX_W = $clog2(MEM_WORDS);
    localparam int BANKS = soc_pkg::MASK_W;

    // Bank k holds the bytes at addresses equal to k modulo 4
    logic [7:0]       bank_mem [BANKS][MEM_WORDS];
    logic [7:0]       bank_q   [BANKS];
    logic [IDX_W-1:0] bank_idx [BANKS];

    logic [IDX_W-1:0] wr_idx;
    logic [IDX_W-1:0] fetch_idx;
    logic [1:0]       fetch_off;
    logic [1:0]       fetch_off_q;

    assign wr_idx    = bus_i.addr[IDX_W+1:2];
    assign fetch_idx = fetch_addr_i[IDX_W+1:2];
    assign fetch_off = fetch_addr_i[1:0];

    // Banks below the byte offset serve the following word
    always_comb begin
        for (int k = 0; k < BANKS; k++) begin
            if (2'(k) < fetch_off) begin
                // Wraps to word 0 past the last word
                bank_idx[k] = fetch_idx + IDX_W'(1);
            end else begin
                bank_idx[k] = fetch_idx;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        for (int k = 0; k < BANKS; k++) begin
            if (bus_i.write && bus_i.size[k]) begin
                bank_mem[k][wr_idx] <= bus_i.wr_data[8*k +: 8];
            end
            bank_q[k] <= bank_mem[k][bank_idx[k]];
        end
        fetch_off_q <= fetch_off;
    end

    // Rotate so byte 0 is the byte at the fetch address
    always_comb begin
        for (int j = 0; j < BANKS; j++) begin
            fetch_rd_data_o[8*j +: 8] = bank_q[fetch_off_q + 2'(j)];
        end
    end

    // No bus read path into this memory
    assign bus_i.rd_data = '0;

endmodule

`default_nettype wire

//--- hw/dmem_sram.sv
`timescale 1ns/1ps
`default_nettype none

module dmem_sram #(
    parameter int MEM_WORDS = 4096
) (
    input  logic     clk_i,
    mem_bus_if.slave bus_i
);

    localparam int IDX_W = $clog2(MEM_WORDS);

    logic [soc_pkg::XLEN-1:0] mem [MEM_WORDS];
    logic [soc_pkg::XLEN-1:0] rd_q;
    logic [IDX_W-1:0]         idx;

    assign idx = bus_i.addr[IDX_W+1:2];

    always_ff @(posedge clk_i) begin
        // Byte-masked write
        if (bus_i.write) begin
            for (int k = 0; k < soc_pkg::MASK_W; k++) begin
                if (bus_i.size[k]) begin
                    mem[idx][8*k +: 8] <= bus_i.wr_data[8*k +: 8];
                end
            end
        end
        // One-cycle read
        if (bus_i.read) begin
            rd_q <= mem[idx];
        end
    end

    assign bus_i.rd_data = rd_q;

endmodule

`default_nettype wire

//--- hw/soc_mem_top.sv
`timescale 1ns/1ps
`default_nettype none

module soc_mem_top (
    input  logic                       clk_i,
    input  logic                       rv_rst_ni,

    // Instruction fetch
    input  logic [soc_pkg::XLEN-1:0]   fetch_addr_i,
    output logic [soc_pkg::XLEN-1:0]   fetch_rd_data_o,

    // Host loader port
    input  logic                       host_req_i,
    output logic                       host_gnt_o,
    input  logic [soc_pkg::XLEN-1:0]   host_addr_i,
    input  logic [soc_pkg::XLEN-1:0]   host_wr_data_i,
    input  logic [soc_pkg::MASK_W-1:0] host_size_i,
    input  logic                       host_read_i,
    input  logic                       host_write_i,
    output logic [soc_pkg::XLEN-1:0]   host_rd_data_o,

    // Core data port
    input  logic                       core_req_i,
    output logic                       core_gnt_o,
    input  logic [soc_pkg::XLEN-1:0]   core_addr_i,
    input  logic [soc_pkg::XLEN-1:0]   core_wr_data_i,
    input  logic [soc_pkg::MASK_W-1:0] core_size_i,
    input  logic                       core_read_i,
    input  logic                       core_write_i,
    output logic [soc_pkg::XLEN-1:0]   core_rd_data_o,

    // PIM controller
    output logic [soc_pkg::XLEN-1:0]   pim_addr_o,
    output logic [soc_pkg::XLEN-1:0]   pim_wr_o,
    input  logic [soc_pkg::XLEN-1:0]   pim_rd_i
);

    mem_bus_if arb_bus ();
    mem_bus_if dmem_bus ();
    mem_bus_if imem_bus ();

    bus_arbiter u_arbiter (
        .host_req_i     (host_req_i),
        .host_addr_i    (host_addr_i),
        .host_wr_data_i (host_wr_data_i),
        .host_size_i    (host_size_i),
        .host_read_i    (host_read_i),
        .host_write_i   (host_write_i),
        .host_gnt_o     (host_gnt_o),
        .core_req_i     (core_req_i),
        .core_addr_i    (core_addr_i),
        .core_wr_data_i (core_wr_data_i),
        .core_size_i    (core_size_i),
        .core_read_i    (core_read_i),
        .core_write_i   (core_write_i),
        .core_gnt_o     (core_gnt_o),
        .bus_o          (arb_bus.master)
    );

    bus_decoder u_decoder (
        .clk_i      (clk_i),
        .rv_rst_ni  (rv_rst_ni),
        .bus_i      (arb_bus.slave),
        .dmem_o     (dmem_bus.master),
        .imem_o     (imem_bus.master),
        .pim_rd_i   (pim_rd_i),
        .pim_addr_o (pim_addr_o),
        .pim_wr_o   (pim_wr_o)
    );

    imem_banked #(
        .MEM_WORDS (soc_pkg::MEM_WORDS_DEF)
    ) u_imem (
        .clk_i           (clk_i),
        .bus_i           (imem_bus.slave),
        .fetch_addr_i    (fetch_addr_i),
        .fetch_rd_data_o (fetch_rd_data_o)
    );

    dmem_sram #(
        .MEM_WORDS (soc_pkg::MEM_WORDS_DEF)
    ) u_dmem (
        .clk_i (clk_i),
        .bus_i (dmem_bus.slave)
    );

    // Shared read data, valid in the cycle after gnt
    assign host_rd_data_o = arb_bus.rd_data;
    assign core_rd_data_o = arb_bus.rd_data;

endmodule

`default_nettype wire

//--- tests/tb_soc_mem.sv
`timescale 1ns/1ps
`default_nettype none

module tb_soc_mem;

    localparam int MEM_WORDS = soc_pkg::MEM_WORDS_DEF;
    localparam int IDX_W     = $clog2(MEM_WORDS);
    localparam int BA_W      = IDX_W + 2;
    localparam int TIMEOUT   = 100;
    localparam int RND_N     = 48;

    logic        clk_i;
    logic        rv_rst_ni;
    logic [31:0] fetch_addr_i;
    logic [31:0] fetch_rd_data_o;
    logic        host_req_i;
    logic        host_gnt_o;
    logic [31:0] host_addr_i;
    logic [31:0] host_wr_data_i;
    logic [3:0]  host_size_i;
    logic        host_read_i;
    logic        host_write_i;
    logic [31:0] host_rd_data_o;
    logic        core_req_i;
    logic        core_gnt_o;
    logic [31:0] core_addr_i;
    logic [31:0] core_wr_data_i;
    logic [3:0]  core_size_i;
    logic        core_read_i;
    logic        core_write_i;
    logic [31:0] core_rd_data_o;
    logic [31:0] pim_addr_o;
    logic [31:0] pim_wr_o;
    logic [31:0] pim_rd_i;

    // Reference model of both memories and the PIM registers
    logic [31:0] imem_model [MEM_WORDS];
    logic [31:0] dmem_model [MEM_WORDS];
    logic [31:0] pim_addr_model;
    logic [31:0] pim_wr_model;

    integer seed;
    int     errors;
    int     checks;

    soc_mem_top u_dut (.*);

    always #5 clk_i = ~clk_i;

    task automatic compare_word(input string name, input string what,
                                input logic [31:0] exp_v, input logic [31:0] act_v);
        checks++;
        if (act_v !== exp_v) begin
            errors++;
            $display("error %s %s expected %h actual %h", name, what, exp_v, act_v);
        end
    endtask

    function automatic logic [31:0] merge_bytes(input logic [31:0] old_v,
                                                input logic [31:0] new_v, input logic [3:0] mask);
        logic [31:0] res;
        res = old_v;
        for (int k = 0; k < 4; k++) begin
            if (mask[k]) begin
                res[8*k +: 8] = new_v[8*k +: 8];
            end
        end
        return res;
    endfunction

    task automatic model_write(input logic [31:0] addr, input logic [31:0] data,
                               input logic [3:0] mask);
        logic [IDX_W-1:0] idx;
        idx = addr[IDX_W+1:2];
        case (addr[31:28])
            4'h1: imem_model[idx] = merge_bytes(imem_model[idx], data, mask);
            4'h2: dmem_model[idx] = merge_bytes(dmem_model[idx], data, mask);
            4'h4: begin
                pim_addr_model = addr;
                pim_wr_model   = data;
            end
            default: ;
        endcase
    endtask

    // Only dmem and PIM answer bus reads
    function automatic logic [31:0] model_read(input logic [31:0] addr);
        case (addr[31:28])
            4'h2:    return dmem_model[addr[IDX_W+1:2]];
            4'h4:    return pim_rd_i;
            default: return 32'h0;
        endcase
    endfunction

    function automatic logic [31:0] model_fetch(input logic [31:0] addr);
        logic [31:0]     res;
        logic [31:0]     word;
        logic [BA_W-1:0] ba;
        for (int j = 0; j < 4; j++) begin
            // Byte address wraps at the end of the memory
            ba   = addr[BA_W-1:0] + BA_W'(j);
            word = imem_model[ba[BA_W-1:2]] >> {ba[1:0], 3'b000};
            res[8*j +: 8] = word[7:0];
        end
        return res;
    endfunction

    task automatic drive_port(input bit core, input logic req, input logic [31:0] addr,
                              input logic [31:0] data, input logic [3:0] mask,
                              input logic rd, input logic wr);
        if (core) begin
            core_req_i     = req;
            core_addr_i    = addr;
            core_wr_data_i = data;
            core_size_i    = mask;
            core_read_i    = rd;
            core_write_i   = wr;
        end else begin
            host_req_i     = req;
            host_addr_i    = addr;
            host_wr_data_i = data;
            host_size_i    = mask;
            host_read_i    = rd;
            host_write_i   = wr;
        end
    endtask

    task automatic wait_grant(input bit core, input string name);
        int n;
        bit got;
        n   = 0;
        got = 1'b0;
        while (!got && n < TIMEOUT) begin
            @(negedge clk_i);
            if ((core ? core_gnt_o : host_gnt_o) === 1'b1) begin
                got = 1'b1;
            end else begin
                n++;
            end
        end
        if (!got) begin
            errors++;
            $display("timeout in %s: no grant within %0d cycles", name, TIMEOUT);
        end
    endtask

    task automatic bus_access(input bit core, input bit wr, input string name,
                              input logic [31:0] addr, input logic [31:0] data,
                              input logic [3:0] mask, output logic [31:0] rd_v);
        @(posedge clk_i);
        #1;
        drive_port(core, 1'b1, addr, data, mask, !wr, wr);
        wait_grant(core, name);
        @(posedge clk_i);
        #1;
        drive_port(core, 1'b0, '0, '0, '0, 1'b0, 1'b0);
        if (wr) begin
            model_write(addr, data, mask);
        end
        // Read data lives only in the cycle after gnt
        @(negedge clk_i);
        rd_v = core ? core_rd_data_o : host_rd_data_o;
    endtask

    // Host writes addr, core writes addr+4 in the same cycle
    task automatic run_both(input string name, input logic [31:0] addr,
                            input logic [31:0] data, input logic [3:0] mask,
                            input logic [31:0] core_data);
        @(posedge clk_i);
        #1;
        drive_port(1'b0, 1'b1, addr, data, mask, 1'b0, 1'b1);
        drive_port(1'b1, 1'b1, addr + 32'd4, core_data, 4'hf, 1'b0, 1'b1);
        @(negedge clk_i);
        compare_word(name, "host_gnt_o", 32'd1, 32'(host_gnt_o));
        compare_word(name, "core_gnt_o", 32'd0, 32'(core_gnt_o));
        @(posedge clk_i);
        #1;
        drive_port(1'b0, 1'b0, '0, '0, '0, 1'b0, 1'b0);
        model_write(addr, data, mask);
        wait_grant(1'b1, name);
        @(posedge clk_i);
        #1;
        drive_port(1'b1, 1'b0, '0, '0, '0, 1'b0, 1'b0);
        model_write(addr + 32'd4, core_data, 4'hf);
        @(negedge clk_i);
    endtask

    task automatic run_case(input string name, input string op, input logic [31:0] addr,
                            input logic [31:0] data, input logic [3:0] mask,
                            input logic [31:0] expect_v);
        logic [31:0] got;
        if (op == "hwr" || op == "cwr") begin
            bus_access(op == "cwr", 1'b1, name, addr, data, mask, got);
        end else if (op == "hrd" || op == "crd" || op == "pimrd") begin
            if (op == "pimrd") begin
                @(posedge clk_i);
                #1;
                pim_rd_i = data;
            end
            compare_word(name, "case file vs model", model_read(addr), expect_v);
            bus_access(op != "hrd", 1'b0, name, addr, '0, '0, got);
            compare_word(name, "read data", expect_v, got);
        end else if (op == "fetch") begin
            compare_word(name, "case file vs model", model_fetch(addr), expect_v);
            @(posedge clk_i);
            #1;
            fetch_addr_i = addr;
            @(posedge clk_i);
            @(negedge clk_i);
            compare_word(name, "fetch data", expect_v, fetch_rd_data_o);
        end else if (op == "both") begin
            run_both(name, addr, data, mask, expect_v);
        end else begin
            errors++;
            $display("unknown operation %s in case %s", op, name);
        end
        // PIM outputs hold between PIM writes
        compare_word(name, "pim_addr_o", pim_addr_model, pim_addr_o);
        compare_word(name, "pim_wr_o", pim_wr_model, pim_wr_o);
    endtask

    initial begin
        int          fd;
        int          n;
        int          n_cases;
        string       line;
        string       name;
        string       op;
        logic [31:0] addr;
        logic [31:0] data;
        logic [3:0]  mask;
        logic [31:0] expect_v;
        logic [31:0] got;
        logic [31:0] rnd_addr [RND_N];

        clk_i        = 1'b0;
        rv_rst_ni    = 1'b0;
        fetch_addr_i = '0;
        pim_rd_i     = '0;
        drive_port(1'b0, 1'b0, '0, '0, '0, 1'b0, 1'b0);
        drive_port(1'b1, 1'b0, '0, '0, '0, 1'b0, 1'b0);
        seed           = 32'h473d_f777;
        errors         = 0;
        checks         = 0;
        n_cases        = 0;
        pim_addr_model = '0;
        pim_wr_model   = '0;

        repeat (10) @(posedge clk_i);
        #1;
        rv_rst_ni = 1'b1;

        // Idle outputs before any request
        @(negedge clk_i);
        compare_word("reset", "host_gnt_o", 32'd0, 32'(host_gnt_o));
        compare_word("reset", "core_gnt_o", 32'd0, 32'(core_gnt_o));
        compare_word("reset", "pim_addr_o", 32'd0, pim_addr_o);
        compare_word("reset", "pim_wr_o", 32'd0, pim_wr_o);
        compare_word("reset", "rd_data", 32'd0, host_rd_data_o);

        fd = $fopen("tests/soc_mem_cases.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("could not open tests/soc_mem_cases.txt");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                n    = $fgets(line, fd);
                n    = $sscanf(line, "%s %s %h %h %h %h", name, op, addr, data, mask, expect_v);
                if (n == 6 && name != "#") begin
                    n_cases++;
                    run_case(name, op, addr, data, mask, expect_v);
                end
            end
            $fclose(fd);
        end
        if (n_cases == 0) begin
            errors++;
            $display("no test cases were read from the case file");
        end

        // Random fill through the host, readback through the core
        for (int i = 0; i < RND_N; i++) begin
            rnd_addr[i] = 32'h2000_0000 | (($unsigned($random(seed)) & 32'h0000_0fff) << 2);
            data        = $random(seed);
            bus_access(1'b0, 1'b1, "rnd_fill", rnd_addr[i], data, 4'hf, got);
        end
        for (int i = 0; i < RND_N; i++) begin
            bus_access(1'b1, 1'b0, "rnd_read", rnd_addr[i], '0, '0, got);
            compare_word("rnd_read", "read data", model_read(rnd_addr[i]), got);
        end

        $display("cases %0d checks %0d errors %0d", n_cases, checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tests/soc_mem_cases.txt
# name op addr data mask expected, all numbers in hex; data is the pim_rd_i value for pimrd
# both: host writes data with mask at addr while the core writes expected to addr+4
dm_full     hwr   20000010 11223344 f 00000000
dm_b0       hwr   20000010 000000aa 1 00000000
dm_b2       hwr   20000010 00bb0000 4 00000000
dm_merge1   hrd   20000010 00000000 0 11bb33aa
dm_hi       cwr   20000010 ccdd0000 c 00000000
dm_merge2   crd   20000010 00000000 0 ccdd33aa
dm_b13      cwr   20000010 ee00ff00 a 00000000
dm_merge3   hrd   20000010 00000000 0 eeddffaa
dm_other    hwr   20000ffc 0badf00d f 00000000
dm_other_rd crd   20000ffc 00000000 0 0badf00d
arb_both    both  20000020 12345678 f 9abcdef0
arb_rd_h    crd   20000020 00000000 0 12345678
arb_rd_c    hrd   20000024 00000000 0 9abcdef0
arb_part    both  20000020 aa000000 8 55667788
arb_part_h  hrd   20000020 00000000 0 aa345678
arb_part_c  crd   20000024 00000000 0 55667788
im_w0       hwr   10000000 03020100 f 00000000
im_w1       hwr   10000004 07060504 f 00000000
im_last     hwr   10003ffc fffefdfc f 00000000
fe_off0     fetch 10000000 00000000 0 03020100
fe_off1     fetch 10000001 00000000 0 04030201
fe_off2     fetch 10000002 00000000 0 05040302
fe_off3     fetch 10000003 00000000 0 06050403
im_hi       cwr   10000004 aa000000 8 00000000
fe_word1    fetch 10000004 00000000 0 aa060504
fe_last0    fetch 10003ffc 00000000 0 fffefdfc
fe_wrap1    fetch 10003ffd 00000000 0 00fffefd
fe_wrap2    fetch 10003ffe 00000000 0 0100fffe
fe_wrap3    fetch 10003fff 00000000 0 020100ff
pim_w1      cwr   40000010 cafef00d f 00000000
pim_rd1     pimrd 40000000 5a5aa5a5 0 5a5aa5a5
unm_wr      hwr   80000000 deadbeef f 00000000
unm_rd      crd   30000000 00000000 0 00000000
im_rd       crd   10000000 00000000 0 00000000
pim_w2      hwr   40000044 01234567 f 00000000
pim_rd2     pimrd 40000100 76543210 0 76543210

//--- filelist.f
hw/soc_pkg.sv
hw/mem_bus_if.sv
hw/bus_arbiter.sv
hw/bus_decoder.sv
hw/imem_banked.sv
hw/dmem_sram.sv
hw/soc_mem_top.sv
tests/tb_soc_mem.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and scan the log
set -o pipefail
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary -f filelist.f --top-module tb_soc_mem -o tb_soc_mem \
    && ./obj_dir/tb_soc_mem 2>&1 | tee sim.log \
    || { echo "Build or simulation run failed"; exit 1; }
[ -s sim.log ] || { echo "Simulation log is empty"; exit 1; }
grep -q "Checks failed" sim.log && { echo "Simulation reported failures"; exit 1; }
echo "Simulation passed"
exit 0
